// ==== design/mcmd_pkg.sv ====
// shared types for the linear page write encoder; command word is 32 bits, pause words use addr low bits
`default_nettype none

package mcmd_pkg;

    typedef logic [14:0] row_addr_t;     // memory row
    typedef logic [6:0]  col_addr_t;     // burst-aligned column, 3 zero lsbs appended on the bus
    typedef logic [2:0]  bank_t;         // bank address
    typedef logic [5:0]  xfer_len_t;     // requested bursts, 0 means 64
    typedef logic [6:0]  burst_cnt_t;    // remaining bursts, one extra bit to hold 64
    typedef logic [3:0]  step_addr_t;    // microcode ROM address
    typedef logic [2:0]  rcw_t;          // RAS/CAS/WE, positive logic

    localparam rcw_t RCW_NOP       = 3'd0;
    localparam rcw_t RCW_WRITE     = 3'd3;
    localparam rcw_t RCW_PRECHARGE = 3'd5;
    localparam rcw_t RCW_ACTIVATE  = 3'd4;

    typedef enum logic [1:0] {
        STEP_NOP       = 2'd0,
        STEP_WRITE     = 2'd1,
        STEP_PRECHARGE = 2'd2,
        STEP_ACTIVATE  = 2'd3
    } step_cmd_e;

    typedef struct packed {
        step_cmd_e   cmd;         // local command code
        logic [1:0]  pause;       // extra idle cycles on a pause word
        logic        nop_after;   // dual-cycle command, NOP follows
        logic        buf_rd;      // external buffer read strobe
        logic        dqs_toggle;
        logic        dq_dqs_en;
        logic        sel;         // half-cycle select
        logic        odt;
        logic        pre_done;    // last step of the sequence
        logic        buf_pgnext;  // advance buffer page
    } seq_step_t;

    typedef struct packed {
        row_addr_t   addr;        // row, column or pause count + done flag
        bank_t       bank;
        rcw_t        rcw;
        logic        odt_en;
        logic        cke;
        logic        sel;
        logic        dq_en;
        logic        dqs_en;
        logic        dqs_toggle;
        logic        dci;
        logic        buf_wr;
        logic        buf_rd;
        logic        nop;
        logic        buf_rst;
    } mcmd_word_t;

    localparam int PAUSE_DONE_BIT = 10;  // done flag position inside addr of a pause word

    localparam step_addr_t CUT_SINGLE_ADDR    = 4'd2;   // buffer read cut point for one burst
    localparam step_addr_t WRITE_ADDR1        = 4'd3;   // first write
    localparam step_addr_t CUT_DUAL_ADDR      = 4'd4;   // cut point for two bursts, also jump source
    localparam step_addr_t REPEAT_ADDR        = 4'd5;   // looping dual-cycle write
    localparam step_addr_t PRELAST_WRITE_ADDR = 4'd6;   // entry for three bursts
    localparam step_addr_t LAST_WRITE_ADDR    = 4'd8;   // entry for two bursts
    localparam step_addr_t NO_WRITE_ADDR      = 4'd10;  // entry for a single burst

    localparam logic WSEL = 1'b0;  // half-cycle used for writes

endpackage

`default_nettype wire

// ==== design/wr_seq_fsm.sv ====
// run FSM and ROM address stepper; start must not arrive while a sequence is running
`default_nettype none

module wr_seq_fsm (
    input  wire logic                 clk,
    input  wire logic                 mrst,
    input  wire logic                 start,
    input  wire mcmd_pkg::seq_step_t  step,
    input  wire logic                 loop_more,
    input  wire logic                 few_write,
    input  wire logic                 single_write,
    input  wire logic                 dual_write,
    output logic                      gen_run,
    output mcmd_pkg::step_addr_t      gen_addr,
    output logic                      write_slot
);
    import mcmd_pkg::*;

    typedef enum logic {
        IDLE,
        RUN
    } run_state_e;

    run_state_e  state;
    step_addr_t  jump_addr;   // shortcut target for 1..3 bursts
    logic        pre_done;    // final ROM step reached

    assign gen_run    = (state == RUN);
    assign pre_done   = step.pre_done && gen_run;
    assign write_slot = gen_run && ((gen_addr == WRITE_ADDR1) || (gen_addr == REPEAT_ADDR));

    always_ff @(posedge clk) begin
        if (mrst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: if (start) state <= RUN;
                RUN:  if (pre_done) state <= IDLE;    // stop flag comes out of the ROM
                default: state <= IDLE;
            endcase
        end
    end

    // address walk, pointer overruns one past the last step before stopping
    always_ff @(posedge clk) begin
        if (mrst) begin
            gen_addr <= '0;
        end else if (!start && !gen_run) begin
            gen_addr <= '0;                           // park on ACTIVATE
        end else if ((gen_addr == CUT_DUAL_ADDR) && few_write) begin
            gen_addr <= jump_addr;                    // skip the loop for short requests
        end else if ((gen_addr != REPEAT_ADDR) || !loop_more) begin
            gen_addr <= gen_addr + 4'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (mrst) begin
            jump_addr <= '0;
        end else begin
            jump_addr <= single_write ? NO_WRITE_ADDR :
                         (dual_write ? LAST_WRITE_ADDR : PRELAST_WRITE_ADDR);
        end
    end

    // a new request only after the current one has finished
    a_no_start_in_run: assert property (@(posedge clk) disable iff (mrst)
        gen_run |-> !start);

    // past address 14 the ROM must already show pre_done and the run must end
    a_addr_in_range: assert property (@(posedge clk) disable iff (mrst)
        (gen_run && (gen_addr > step_addr_t'(14))) |-> (step.pre_done ##1 !gen_run));

endmodule

`default_nettype wire

// ==== design/burst_counter.sv ====
// burst countdown and column stepping; flags are valid from the second cycle after start
`default_nettype none

module burst_counter (
    input  wire logic                 clk,
    input  wire logic                 mrst,
    input  wire logic                 start,
    input  wire mcmd_pkg::xfer_len_t  num128_in,
    input  wire mcmd_pkg::col_addr_t  start_col,
    input  wire logic                 gen_run,
    input  wire logic                 write_slot,
    input  wire mcmd_pkg::seq_step_t  step,
    output logic                      loop_more,
    output logic                      few_write,
    output logic                      single_write,
    output logic                      dual_write,
    output mcmd_pkg::col_addr_t       col
);
    import mcmd_pkg::*;

    burst_cnt_t  num128;    // bursts left to issue
    logic        start_d;   // flags sampled one cycle after load

    assign loop_more = (num128[6:2] != '0);   // four or more left

    always_ff @(posedge clk) begin
        if (mrst) begin
            num128       <= '0;
            start_d      <= 1'b0;
            single_write <= 1'b0;
            dual_write   <= 1'b0;
            few_write    <= 1'b0;
        end else begin
            start_d <= start;
            if (start) begin
                num128 <= {(num128_in == '0), num128_in};   // 0 expands to 64
            end else if (!gen_run) begin
                num128 <= '0;
            end else if (write_slot) begin
                num128 <= num128 - 7'd1;
            end
            if (start_d) begin
                single_write <= (num128[6:1] == '0);          // zero not possible here
                dual_write   <= (num128 == 7'd2);
                few_write    <= (num128[6:2] == '0);          // 1, 2 or 3
            end
        end
    end

    // column bumps after every write step goes out
    always_ff @(posedge clk) begin
        if (start) begin
            col <= start_col;
        end else if (step.cmd == STEP_WRITE) begin
            col <= col + 7'd1;
        end
    end

    // the FSM must not ask for more writes than were requested
    a_no_underflow: assert property (@(posedge clk) disable iff (mrst)
        write_slot |-> (num128 != '0));

endmodule

`default_nettype wire

// ==== design/seq_rom.sv ====
// registered microcode table, output lags the address by one clock; unused addresses read NOP
`default_nettype none

module seq_rom (
    input  wire logic                  clk,
    input  wire logic                  mrst,
    input  wire mcmd_pkg::step_addr_t  gen_addr,
    output mcmd_pkg::seq_step_t        step
);
    import mcmd_pkg::*;

    seq_step_t rom_w;

    // positional order matches seq_step_t fields
    function automatic seq_step_t mk_step(step_cmd_e cmd, logic [1:0] pause, logic nop_after,
                                          logic buf_rd, logic dqs_toggle, logic dq_dqs_en,
                                          logic sel, logic odt, logic pre_done,
                                          logic buf_pgnext);
        return '{cmd, pause, nop_after, buf_rd, dqs_toggle, dq_dqs_en, sel, odt, pre_done,
                 buf_pgnext};
    endfunction

    //                                 cmd          pse   nop   rd    tgl   en    sel   odt   pd    pg
    always_comb begin
        case (gen_addr)
            4'd0:  rom_w = mk_step(STEP_ACTIVATE, 2'd0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
            4'd1:  rom_w = mk_step(STEP_NOP,      2'd0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
            4'd2:  rom_w = mk_step(STEP_NOP,      2'd0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
            4'd3:  rom_w = mk_step(STEP_WRITE,    2'd0, 1'b0, 1'b1, 1'b0, 1'b0, WSEL, 1'b1, 1'b0, 1'b0);
            4'd4:  rom_w = mk_step(STEP_NOP,      2'd0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
            4'd5:  rom_w = mk_step(STEP_WRITE,    2'd0, 1'b1, 1'b1, 1'b1, 1'b1, WSEL, 1'b1, 1'b0, 1'b0);
            4'd6:  rom_w = mk_step(STEP_WRITE,    2'd0, 1'b0, 1'b1, 1'b1, 1'b1, WSEL, 1'b1, 1'b0, 1'b0);
            4'd7:  rom_w = mk_step(STEP_NOP,      2'd0, 1'b0, 1'b0, 1'b1, 1'b1, WSEL, 1'b1, 1'b0, 1'b0);
            4'd8:  rom_w = mk_step(STEP_WRITE,    2'd0, 1'b0, 1'b0, 1'b1, 1'b1, WSEL, 1'b1, 1'b0, 1'b0);
            4'd9:  rom_w = mk_step(STEP_NOP,      2'd0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0);
            4'd10: rom_w = mk_step(STEP_NOP,      2'd2, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0);
            4'd11: rom_w = mk_step(STEP_NOP,      2'd2, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
            4'd12: rom_w = mk_step(STEP_PRECHARGE, 2'd0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
            4'd13: rom_w = mk_step(STEP_NOP,      2'd2, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
            4'd14: rom_w = mk_step(STEP_NOP,      2'd0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
            default: rom_w = mk_step(STEP_NOP,    2'd0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        endcase
    end

    always_ff @(posedge clk) begin
        if (mrst) begin
            step <= '0;
        end else begin
            step <= rom_w;      // 3 is single-cycle, 5 loops, 6 and 8 finish the burst train
        end
    end

endmodule

`default_nettype wire

// ==== design/cmd_word_encoder.sv ====
// packs ROM steps into command words; row, bank and skip are sampled only on start
`default_nettype none

module cmd_word_encoder (
    input  wire logic                  clk,
    input  wire logic                  mrst,
    input  wire logic                  start,
    input  wire mcmd_pkg::bank_t       bank_in,
    input  wire mcmd_pkg::row_addr_t   row_in,
    input  wire logic                  skip_next_page_in,
    input  wire logic                  gen_run,
    input  wire mcmd_pkg::seq_step_t   step,
    input  wire mcmd_pkg::col_addr_t   col,
    input  wire logic                  single_write,
    input  wire logic                  dual_write,
    input  wire mcmd_pkg::step_addr_t  gen_addr,
    output mcmd_pkg::mcmd_word_t       enc_cmd,
    output logic                       enc_wr,
    output logic                       enc_done
);
    import mcmd_pkg::*;

    row_addr_t   row;
    bank_t       bank;
    logic        skip_next_page;
    logic        cut_buf_rd;     // sticky, holds buf_rd low until the read run ends
    logic        cut_here;
    rcw_t        rcw_w;
    mcmd_word_t  word_w;

    assign cut_here = single_write ? (gen_addr == CUT_SINGLE_ADDR) :
                      (dual_write && (gen_addr == CUT_DUAL_ADDR));

    always_ff @(posedge clk) begin
        if (start) begin
            row            <= row_in;
            bank           <= bank_in;
            skip_next_page <= skip_next_page_in;
        end
    end

    always_comb begin
        case (step.cmd)
            STEP_WRITE:     rcw_w = RCW_WRITE;
            STEP_PRECHARGE: rcw_w = RCW_PRECHARGE;
            STEP_ACTIVATE:  rcw_w = RCW_ACTIVATE;
            default:        rcw_w = RCW_NOP;
        endcase
    end

    always_comb begin
        word_w            = '0;                   // cke, dci, buf_wr stay low
        word_w.bank       = bank;
        word_w.odt_en     = step.odt;
        word_w.sel        = step.sel;
        word_w.dq_en      = step.dq_dqs_en;
        word_w.dqs_en     = step.dq_dqs_en;
        word_w.dqs_toggle = step.dqs_toggle;
        word_w.buf_rd     = step.buf_rd && !cut_buf_rd;
        word_w.buf_rst    = step.buf_pgnext && !skip_next_page;
        if (step.cmd == STEP_NOP) begin
            word_w.rcw                  = RCW_NOP;
            word_w.addr[1:0]            = step.pause;       // pause word
            word_w.addr[PAUSE_DONE_BIT] = step.pre_done;
        end else begin
            word_w.rcw  = rcw_w;
            word_w.addr = (step.cmd == STEP_WRITE) ? row_addr_t'({col, 3'b000}) : row;
            word_w.nop  = step.nop_after;
        end
    end

    always_ff @(posedge clk) begin
        if (mrst) begin
            enc_cmd    <= '0;
            enc_wr     <= 1'b0;
            enc_done   <= 1'b0;
            cut_buf_rd <= 1'b0;
        end else begin
            enc_wr     <= gen_run;
            enc_done   <= enc_wr && !gen_run;   // trailing edge of the word stream
            cut_buf_rd <= step.buf_rd && (cut_buf_rd || cut_here);
            if (gen_run) begin
                enc_cmd <= word_w;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/linear_wr_encoder.sv ====
// linear page write command generator; no back-pressure, one word per clock while enc_wr is high
`default_nettype none

module linear_wr_encoder (
    input  wire logic                 clk,
    input  wire logic                 mrst,
    input  wire logic                 start,
    input  wire mcmd_pkg::bank_t      bank_in,
    input  wire mcmd_pkg::row_addr_t  row_in,
    input  wire mcmd_pkg::col_addr_t  start_col,
    input  wire mcmd_pkg::xfer_len_t  num128_in,
    input  wire logic                 skip_next_page_in,
    output mcmd_pkg::mcmd_word_t      enc_cmd,
    output logic                      enc_wr,
    output logic                      enc_done
);
    import mcmd_pkg::*;

    logic        gen_run;
    step_addr_t  gen_addr;
    logic        write_slot;
    seq_step_t   step;
    logic        loop_more;
    logic        few_write;
    logic        single_write;
    logic        dual_write;
    col_addr_t   col;

    wr_seq_fsm fsm_i (
        .clk, .mrst, .start, .step, .loop_more, .few_write, .single_write, .dual_write,
        .gen_run, .gen_addr, .write_slot
    );

    burst_counter cnt_i (
        .clk, .mrst, .start, .num128_in, .start_col, .gen_run, .write_slot, .step,
        .loop_more, .few_write, .single_write, .dual_write, .col
    );

    seq_rom rom_i (
        .clk, .mrst, .gen_addr, .step
    );

    cmd_word_encoder enc_i (
        .clk, .mrst, .start, .bank_in, .row_in, .skip_next_page_in, .gen_run, .step, .col,
        .single_write, .dual_write, .gen_addr, .enc_cmd, .enc_wr, .enc_done
    );

endmodule

`default_nettype wire

// ==== dv/linear_wr_tb.sv ====
// reads dv/linear_wr_cases.txt relative to the run directory; stops at the first failed check
`default_nettype none

module linear_wr_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import mcmd_pkg::*;

    localparam int TIMEOUT = 200;            // cycles allowed per wait

    logic        clk;
    logic        mrst;
    logic        start;
    logic        skip_next_page_in;
    bank_t       bank_in;
    row_addr_t   row_in;
    col_addr_t   start_col;
    xfer_len_t   num128_in;
    mcmd_word_t  enc_cmd;
    logic        enc_wr;
    logic        enc_done;
    mcmd_word_t  words[$];                   // one sequence as seen on enc_cmd

    linear_wr_encoder dut_i (
        .clk, .mrst, .start, .bank_in, .row_in, .start_col, .num128_in, .skip_next_page_in,
        .enc_cmd, .enc_wr, .enc_done
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;               // 4 ns period
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input string what, input mcmd_word_t exp, input mcmd_word_t act);
        if (act !== exp)
            fail_run($sformatf("MISMATCH %s expected %h actual %h", what, exp, act));
    endtask

    task automatic check_count(input string what, input burst_cnt_t exp, input burst_cnt_t act);
        if (act !== exp)
            fail_run($sformatf("MISMATCH %s expected %0d actual %0d", what, exp, act));
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp)
            fail_run($sformatf("MISMATCH %s expected %b actual %b", what, exp, act));
    endtask

    // keeps only the command, address and bank of a word
    function automatic mcmd_word_t key_fields(input mcmd_word_t w);
        mcmd_word_t k;
        k      = '0;
        k.addr = w.addr;
        k.bank = w.bank;
        k.rcw  = w.rcw;
        return k;
    endfunction

    function automatic mcmd_word_t cmd_key(input rcw_t rcw, input row_addr_t addr,
                                           input bank_t bank);
        mcmd_word_t k;
        k      = '0;
        k.addr = addr;
        k.bank = bank;
        k.rcw  = rcw;
        return k;
    endfunction

    task automatic run_request(input string name, input bank_t bank, input row_addr_t row,
                               input col_addr_t col, input xfer_len_t len, input logic skip,
                               input burst_cnt_t exp_words, input burst_cnt_t exp_rd);
        burst_cnt_t  n_exp;
        burst_cnt_t  n_wr;
        burst_cnt_t  n_rd;
        burst_cnt_t  n_pre;
        col_addr_t   wcol;
        mcmd_word_t  w;
        int          latency;
        int          pre_idx;
        int          last_wr;
        n_exp = (len == '0) ? 7'd64 : {1'b0, len};      // 0 requests a full page
        @(posedge clk);
        start             <= 1'b1;
        bank_in           <= bank;
        row_in            <= row;
        start_col         <= col;
        num128_in         <= len;
        skip_next_page_in <= skip;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);                                  // cycle 1
        latency = 1;
        while (!enc_wr) begin
            @(negedge clk);
            latency++;
            if (latency > TIMEOUT)
                fail_run($sformatf("%s: timeout waiting for enc_wr to rise", name));
        end
        check_count({name, " enc_wr latency"}, 7'd2, burst_cnt_t'(latency));
        words.delete();
        while (enc_wr) begin
            words.push_back(enc_cmd);
            @(negedge clk);
            if (words.size() > TIMEOUT)
                fail_run($sformatf("%s: timeout waiting for enc_wr to fall", name));
        end
        check_flag({name, " enc_done after last word"}, 1'b1, enc_done);
        @(negedge clk);
        check_flag({name, " enc_done one cycle"}, 1'b0, enc_done);
        n_wr    = '0;
        n_rd    = '0;
        n_pre   = '0;
        pre_idx = -1;
        last_wr = -1;
        check_word({name, " activate"}, cmd_key(RCW_ACTIVATE, row, bank), key_fields(words[0]));
        foreach (words[i]) begin
            w = words[i];
            if (w.rcw == RCW_WRITE) begin
                wcol = col + col_addr_t'(n_wr);          // column wraps inside the page
                check_word($sformatf("%s write %0d", name, n_wr),
                           cmd_key(RCW_WRITE, row_addr_t'({wcol, 3'b000}), bank), key_fields(w));
                n_wr++;
                last_wr = i;
            end
            if (w.rcw == RCW_PRECHARGE) begin
                check_word({name, " precharge"}, cmd_key(RCW_PRECHARGE, row, bank),
                           key_fields(w));
                check_flag({name, " precharge buf_rst"}, !skip, w.buf_rst);
                n_pre++;
                pre_idx = i;
            end
            if (w.buf_rd)
                n_rd++;
            check_flag($sformatf("%s done flag word %0d", name, i), i == words.size() - 1,
                       (w.rcw == RCW_NOP) && w.addr[PAUSE_DONE_BIT]);   // only the last one
        end
        check_count({name, " write count"}, n_exp, n_wr);
        check_count({name, " precharge count"}, 7'd1, n_pre);
        check_flag({name, " precharge after writes"}, 1'b1, pre_idx > last_wr);
        check_count({name, " word count"}, exp_words, burst_cnt_t'(words.size()));
        check_count({name, " buf_rd count"}, exp_rd, n_rd);
    endtask

    initial begin
        int     fd;
        int     n_cases;
        int     rc;
        int     bank_v;
        int     row_v;
        int     col_v;
        int     len_v;
        int     skip_v;
        int     words_v;
        int     rd_v;
        string  line;
        string  name;
        mrst              = 1'b1;
        start             = 1'b0;
        skip_next_page_in = 1'b0;
        bank_in           = '0;
        row_in            = '0;
        start_col         = '0;
        num128_in         = '0;
        n_cases           = 0;
        repeat (8) @(posedge clk);
        mrst <= 1'b0;
        repeat (4) begin                                 // quiet outputs before any start
            @(negedge clk);
            check_flag("reset enc_wr", 1'b0, enc_wr);
            check_flag("reset enc_done", 1'b0, enc_done);
            check_word("reset enc_cmd", '0, enc_cmd);
        end
        fd = $fopen("dv/linear_wr_cases.txt", "r");
        if (fd == 0)
            fail_run("cannot open dv/linear_wr_cases.txt for reading");
        while (!$feof(fd)) begin
            line = "";
            rc   = $fgets(line, fd);
            if (line.len() > 1 && line[0] != "#") begin   // skip header and blank lines
                rc = $sscanf(line, "%s %d %h %d %d %d %d %d", name, bank_v, row_v, col_v,
                             len_v, skip_v, words_v, rd_v);
                if (rc != 8)
                    fail_run({"malformed line in cases file: ", line});
                run_request(name, bank_t'(bank_v), row_addr_t'(row_v), col_addr_t'(col_v),
                            xfer_len_t'(len_v), skip_v != 0, burst_cnt_t'(words_v),
                            burst_cnt_t'(rd_v));
                n_cases++;
            end
        end
        $fclose(fd);
        if (n_cases == 0)
            fail_run("no requests found in the cases file");
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
design/mcmd_pkg.sv
design/wr_seq_fsm.sv
design/burst_counter.sv
design/seq_rom.sv
design/cmd_word_encoder.sv
design/linear_wr_encoder.sv
dv/linear_wr_tb.sv

// ==== Makefile ====
# Verilator build and run of the linear page write encoder testbench
SIM      := verilator
FLAGS    := --binary --assert --timescale 1ns/1ps -j 0
TOP      := linear_wr_tb
FILELIST := sim.f
PASS_MSG := ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// ==== dv/linear_wr_cases.txt ====
# name bank(dec) row(hex) start_col(dec) bursts(dec, 0 = 64) skip(0/1) words(dec) buf_rd(dec)
# one request per line, run back to back in file order
single       0  0000  0    1   0  10  2
dual         3  1a2b  17   2   1  12  4
triple       5  7fff  126  3   0  14  6
quad         1  0001  40   4   0  15  7
five         2  4321  100  5   1  16  8
eight        7  2aaa  120  8   0  19  11
sixteen      6  5555  64   16  1  27  19
wrap32       4  3c3c  127  32  0  43  35
full64       0  0bad  0    0   0  75  67
full64_skip  7  7000  5    0   1  75  67
single_skip  2  1234  127  1   1  10  2
dual_wrap    1  0fff  127  2   0  12  4
